/* Bender.yml */
package:
  name: blimp

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/blimp_pkg.sv
      - design/fetch_unit.sv
      - design/decode_issue_unit.sv
      - design/alu_unit.sv
      - design/mul_unit.sv
      - design/writeback_commit_unit.sv
      - design/blimp_core.sv
  - target: simulation
    files:
      - dv/blimp_tb.sv

/* design/alu_unit.sv */
// --------------------
// Blimp ALU pipe
// Single-cycle add for add and addi
// --------------------
`timescale 1ns/100ps
`default_nettype none

module alu_unit
  import blimp_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire d2x_t d2x,
  input  wire logic d2x_val,
  output x2w_t      x2w,
  output logic      x2w_val
);

  x2w_t res_q;
  logic val_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      val_q <= 1'b0;
    end else begin
      val_q <= d2x_val;
    end
  end

  // Result and tag, wrapped 32-bit sum
  always_ff @(posedge clk) begin
    res_q.seq   <= d2x.seq;
    res_q.pc    <= d2x.pc;
    res_q.waddr <= d2x.waddr;
    res_q.wen   <= d2x.wen;
    res_q.wdata <= d2x.op_a + d2x.op_b;
  end

  assign x2w     = res_q;
  assign x2w_val = val_q;

endmodule

`default_nettype wire

/* design/blimp_core.sv */
// --------------------
// Blimp core top level
// Fetch, decode, ALU and multiplier pipes, commit
// --------------------
`timescale 1ns/100ps
`default_nettype none

module blimp_core
  import blimp_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,

  // Instruction memory
  output mem_req_t       mem_req,
  output logic           mem_req_val,
  input  wire logic      mem_req_rdy,
  input  wire mem_resp_t mem_resp,
  input  wire logic      mem_resp_val,

  // Instruction trace
  output commit_t        trace,
  output logic           trace_val
);

  // --------------------
  // Unit links
  // --------------------
  f2d_t    f2d;
  logic    f2d_val;
  logic    f2d_rdy;
  d2x_t    d2x_alu;
  d2x_t    d2x_mul;
  logic    d2x_alu_val;
  logic    d2x_mul_val;
  x2w_t    x2w_alu;
  x2w_t    x2w_mul;
  logic    x2w_alu_val;
  logic    x2w_mul_val;
  commit_t commit;
  logic    commit_val;

  fetch_unit fetch_unit_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_req      (mem_req),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp     (mem_resp),
    .mem_resp_val (mem_resp_val),
    .f2d          (f2d),
    .f2d_val      (f2d_val),
    .f2d_rdy      (f2d_rdy)
  );

  decode_issue_unit decode_issue_unit_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .f2d         (f2d),
    .f2d_val     (f2d_val),
    .f2d_rdy     (f2d_rdy),
    .d2x_alu     (d2x_alu),
    .d2x_mul     (d2x_mul),
    .d2x_alu_val (d2x_alu_val),
    .d2x_mul_val (d2x_mul_val),
    .commit      (commit),
    .commit_val  (commit_val)
  );

  // Execute pipes
  alu_unit alu_unit_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .d2x     (d2x_alu),
    .d2x_val (d2x_alu_val),
    .x2w     (x2w_alu),
    .x2w_val (x2w_alu_val)
  );

  mul_unit mul_unit_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .d2x     (d2x_mul),
    .d2x_val (d2x_mul_val),
    .x2w     (x2w_mul),
    .x2w_val (x2w_mul_val)
  );

  writeback_commit_unit writeback_commit_unit_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .x2w_alu     (x2w_alu),
    .x2w_mul     (x2w_mul),
    .x2w_alu_val (x2w_alu_val),
    .x2w_mul_val (x2w_mul_val),
    .commit      (commit),
    .commit_val  (commit_val)
  );

  // Commit record doubles as trace
  assign trace     = commit;
  assign trace_val = commit_val;

endmodule

`default_nettype wire

/* design/blimp_pkg.sv */
// --------------------
// Blimp core shared types
// Instruction formats and inter-unit records
// --------------------
`default_nettype none

`include "blimp_defs.svh"

package blimp_pkg;

  // RV32 encodings used by the core
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] F7_MULDIV  = 7'b0000001;
  localparam logic [2:0] F3_ADD     = 3'b000;

  // --------------------
  // Instruction word
  // --------------------
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // Same word, read per opcode
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } inst_t;

  typedef enum logic [1:0] {
    OP_ADD,
    OP_ADDI,
    OP_MUL
  } op_t;

  typedef logic [`BLIMP_SEQ_BITS-1:0] seq_t;

  // --------------------
  // Unit boundaries
  // --------------------
  typedef struct packed {
    logic [31:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic [31:0] data;
  } mem_resp_t;

  typedef struct packed {
    logic [31:0] pc;
    inst_t       inst;
  } f2d_t;

  typedef struct packed {
    seq_t        seq;
    logic [31:0] pc;
    logic [4:0]  waddr;
    logic        wen;
    logic [31:0] op_a;
    logic [31:0] op_b;
  } d2x_t;

  typedef struct packed {
    seq_t        seq;
    logic [31:0] pc;
    logic [4:0]  waddr;
    logic        wen;
    logic [31:0] wdata;
  } x2w_t;

  // Commit notice, doubles as trace record
  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  waddr;
    logic        wen;
    logic [31:0] wdata;
  } commit_t;

endpackage

`default_nettype wire

/* design/decode_issue_unit.sv */
// --------------------
// Blimp decode and issue
// Register file, scoreboard, sequence tagging
// and dispatch to the ALU or multiplier pipe
// --------------------
`timescale 1ns/100ps
`default_nettype none

`include "blimp_defs.svh"

module decode_issue_unit
  import blimp_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    rst_n,
  input  wire f2d_t    f2d,
  input  wire logic    f2d_val,
  output logic         f2d_rdy,
  output d2x_t         d2x_alu,
  output d2x_t         d2x_mul,
  output logic         d2x_alu_val,
  output logic         d2x_mul_val,
  input  wire commit_t commit,
  input  wire logic    commit_val
);

  localparam logic [`BLIMP_SEQ_BITS:0] ROB_DEPTH = 1 << `BLIMP_SEQ_BITS;

  logic [31:0]               rf_q [`BLIMP_NUM_REGS];
  logic [`BLIMP_NUM_REGS-1:0] pending_q;
  logic [`BLIMP_SEQ_BITS:0]  inflight_q;
  seq_t                      seq_q;

  inst_t       inst;
  op_t         op;
  logic        op_legal;
  logic [31:0] imm;
  logic [31:0] rdata1;
  logic [31:0] rdata2;
  logic        src1_busy;
  logic        src2_busy;
  logic        dst_busy;
  logic        rob_full;
  logic        issue;
  d2x_t        d2x;

  assign inst = f2d.inst;

  // --------------------
  // Decode
  // --------------------
  always_comb begin
    op       = OP_ADD;
    op_legal = 1'b0;
    if (inst.r.opcode == OPC_OP && inst.r.funct3 == F3_ADD) begin
      // R-type where funct7 picks add or mul
      if (inst.r.funct7 == F7_BASE) begin
        op       = OP_ADD;
        op_legal = 1'b1;
      end else if (inst.r.funct7 == F7_MULDIV) begin
        op       = OP_MUL;
        op_legal = 1'b1;
      end
    end else if (inst.i.opcode == OPC_OP_IMM && inst.i.funct3 == F3_ADD) begin
      op       = OP_ADDI;
      op_legal = 1'b1;
    end
  end

  // Sign-extended I-type immediate
  assign imm = {{20{inst.i.imm12[11]}}, inst.i.imm12};

  // Register read with x0 hardwired to zero
  assign rdata1 = (inst.r.rs1 == 5'd0) ? '0 : rf_q[inst.r.rs1];
  assign rdata2 = (inst.r.rs2 == 5'd0) ? '0 : rf_q[inst.r.rs2];

  // --------------------
  // Hazards
  // --------------------
  // x0 is never marked pending
  assign src1_busy = pending_q[inst.r.rs1];
  assign src2_busy = (op != OP_ADDI) && pending_q[inst.r.rs2];
  assign dst_busy  = pending_q[inst.r.rd];
  assign rob_full  = (inflight_q == ROB_DEPTH);

  assign f2d_rdy = !(src1_busy || src2_busy || dst_busy || rob_full);
  assign issue   = f2d_val && f2d_rdy;

  // Tagged record shared by both pipes
  assign d2x.seq   = seq_q;
  assign d2x.pc    = f2d.pc;
  assign d2x.waddr = inst.r.rd;
  assign d2x.wen   = (inst.r.rd != 5'd0);
  assign d2x.op_a  = rdata1;
  assign d2x.op_b  = (op == OP_ADDI) ? imm : rdata2;

  assign d2x_alu     = d2x;
  assign d2x_mul     = d2x;
  assign d2x_alu_val = issue && (op != OP_MUL);
  assign d2x_mul_val = issue && (op == OP_MUL);

  // --------------------
  // Scoreboard and counters
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending_q  <= '0;
      inflight_q <= '0;
      seq_q      <= '0;
    end else begin
      // Release on commit before claim on issue
      if (commit_val && commit.wen) begin
        pending_q[commit.waddr] <= 1'b0;
      end
      if (issue && d2x.wen) begin
        pending_q[inst.r.rd] <= 1'b1;
      end
      if (issue) begin
        seq_q <= seq_q + 1'b1;
      end
      case ({issue, commit_val})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  // Architectural write at commit
  always_ff @(posedge clk) begin
    if (commit_val && commit.wen) begin
      rf_q[commit.waddr] <= commit.wdata;
    end
  end

  // Program stream only holds add, addi and mul
  legal_issue_a: assert property (@(posedge clk) disable iff (!rst_n)
    issue |-> op_legal);

  // Commit only frees a register claimed at issue
  release_pending_a: assert property (@(posedge clk) disable iff (!rst_n)
    (commit_val && commit.wen) |-> pending_q[commit.waddr]);

endmodule

`default_nettype wire

/* design/fetch_unit.sv */
// --------------------
// Blimp fetch unit
// Sequential PC, one open memory request,
// one-entry buffer toward decode
// --------------------
`timescale 1ns/100ps
`default_nettype none

module fetch_unit
  import blimp_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  output mem_req_t       mem_req,
  output logic           mem_req_val,
  input  wire logic      mem_req_rdy,
  input  wire mem_resp_t mem_resp,
  input  wire logic      mem_resp_val,
  output f2d_t           f2d,
  output logic           f2d_val,
  input  wire logic      f2d_rdy
);

  logic [31:0] pc_q;
  logic        req_val_q;
  logic        req_open_q;
  logic        buf_val_q;
  f2d_t        buf_q;

  logic        req_fire;
  logic        buf_free;

  assign req_fire = req_val_q && mem_req_rdy;
  // Buffer empty now or drained this cycle
  assign buf_free = !buf_val_q || f2d_rdy;

  // --------------------
  // Control state
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q       <= '0;
      req_val_q  <= 1'b0;
      req_open_q <= 1'b0;
      buf_val_q  <= 1'b0;
    end else begin
      // Present next request once fetch is idle
      if (req_fire) begin
        req_val_q  <= 1'b0;
        req_open_q <= 1'b1;
        pc_q       <= pc_q + 32'd4;
      end else if (!req_val_q && !req_open_q && buf_free) begin
        req_val_q <= 1'b1;
      end
      if (mem_resp_val) begin
        req_open_q <= 1'b0;
        buf_val_q  <= 1'b1;
      end else if (buf_val_q && f2d_rdy) begin
        buf_val_q <= 1'b0;
      end
    end
  end

  // Response payload, paired with its fetch address
  always_ff @(posedge clk) begin
    if (mem_resp_val) begin
      buf_q.pc   <= pc_q - 32'd4;
      buf_q.inst <= mem_resp.data;
    end
  end

  assign mem_req.addr = pc_q;
  assign mem_req_val  = req_val_q;
  assign f2d          = buf_q;
  assign f2d_val      = buf_val_q;

  // Memory only answers an accepted request
  resp_has_req_a: assert property (@(posedge clk) disable iff (!rst_n)
    mem_resp_val |-> req_open_q);

endmodule

`default_nettype wire

/* design/mul_unit.sv */
// --------------------
// Blimp multiplier pipe
// Fully pipelined, low word of the product
// --------------------
`timescale 1ns/100ps
`default_nettype none

`include "blimp_defs.svh"

module mul_unit
  import blimp_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire d2x_t d2x,
  input  wire logic d2x_val,
  output x2w_t      x2w,
  output logic      x2w_val
);

  localparam int unsigned STAGES = `BLIMP_MUL_STAGES;

  x2w_t              pipe_q [STAGES];
  logic [STAGES-1:0] val_q;
  logic [63:0]       product;

  // Full product, only the low word is kept
  assign product = 64'(d2x.op_a) * 64'(d2x.op_b);

  // --------------------
  // Valid shift chain
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      val_q <= '0;
    end else begin
      val_q <= {val_q[STAGES-2:0], d2x_val};
    end
  end

  // Payload stages, new entry each cycle
  always_ff @(posedge clk) begin
    pipe_q[0].seq   <= d2x.seq;
    pipe_q[0].pc    <= d2x.pc;
    pipe_q[0].waddr <= d2x.waddr;
    pipe_q[0].wen   <= d2x.wen;
    pipe_q[0].wdata <= product[31:0];
    for (int i = 1; i < STAGES; i++) begin
      pipe_q[i] <= pipe_q[i-1];
    end
  end

  // Last stage drives writeback
  assign x2w     = pipe_q[STAGES-1];
  assign x2w_val = val_q[STAGES-1];

endmodule

`default_nettype wire

/* design/writeback_commit_unit.sv */
// --------------------
// Blimp writeback and commit
// Reorder buffer by sequence tag,
// one in-order commit per cycle
// --------------------
`timescale 1ns/100ps
`default_nettype none

`include "blimp_defs.svh"

module writeback_commit_unit
  import blimp_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire x2w_t x2w_alu,
  input  wire x2w_t x2w_mul,
  input  wire logic x2w_alu_val,
  input  wire logic x2w_mul_val,
  output commit_t   commit,
  output logic      commit_val
);

  localparam int unsigned ROB_DEPTH = 1 << `BLIMP_SEQ_BITS;

  commit_t              rob_q [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] done_q;
  seq_t                 head_q;

  // Drop the tag, keep the record
  function automatic commit_t to_commit(input x2w_t x);
    commit_t c;
    c.pc    = x.pc;
    c.waddr = x.waddr;
    c.wen   = x.wen;
    c.wdata = x.wdata;
    return c;
  endfunction

  // --------------------
  // Completion write
  // --------------------
  always_ff @(posedge clk) begin
    if (x2w_alu_val) begin
      rob_q[x2w_alu.seq] <= to_commit(x2w_alu);
    end
    if (x2w_mul_val) begin
      rob_q[x2w_mul.seq] <= to_commit(x2w_mul);
    end
  end

  // Done bits and head pointer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done_q <= '0;
      head_q <= '0;
    end else begin
      if (commit_val) begin
        done_q[head_q] <= 1'b0;
        head_q         <= head_q + 1'b1;
      end
      if (x2w_alu_val) begin
        done_q[x2w_alu.seq] <= 1'b1;
      end
      if (x2w_mul_val) begin
        done_q[x2w_mul.seq] <= 1'b1;
      end
    end
  end

  // --------------------
  // In-order commit
  // --------------------
  assign commit_val = done_q[head_q];
  assign commit     = rob_q[head_q];

  // Tag reuse only after the slot has committed
  alu_slot_free_a: assert property (@(posedge clk) disable iff (!rst_n)
    x2w_alu_val |-> !done_q[x2w_alu.seq]);

  mul_slot_free_a: assert property (@(posedge clk) disable iff (!rst_n)
    x2w_mul_val |-> !done_q[x2w_mul.seq]);

  // Two pipes never finish the same tag
  distinct_seq_a: assert property (@(posedge clk) disable iff (!rst_n)
    (x2w_alu_val && x2w_mul_val) |-> (x2w_alu.seq != x2w_mul.seq));

endmodule

`default_nettype wire

/* dv/blimp_tb.sv */
// --------------------
// Blimp core testbench
// Random add/addi/mul program on a random-latency memory,
// in-order golden model checked at every trace record
// --------------------
`timescale 1ns/100ps
`default_nettype none

module blimp_tb
  import blimp_pkg::*;
();

  localparam int          PROG_LEN = 200;
  localparam int          TIMEOUT  = 2000;
  localparam int          K_ADD    = 0;
  localparam int          K_ADDI   = 1;
  localparam int          K_MUL    = 2;
  // addi x0, x0, 0
  localparam logic [31:0] NOP_WORD = 32'h0000_0013;

  logic      clk;
  logic      rst_n;
  mem_req_t  mem_req;
  logic      mem_req_val;
  logic      mem_req_rdy;
  mem_resp_t mem_resp;
  logic      mem_resp_val;
  commit_t   trace;
  logic      trace_val;

  // Program as fields and as encoded words
  int          p_op  [PROG_LEN];
  logic [4:0]  p_rd  [PROG_LEN];
  logic [4:0]  p_rs1 [PROG_LEN];
  logic [4:0]  p_rs2 [PROG_LEN];
  logic [11:0] p_imm [PROG_LEN];
  logic [31:0] imem  [PROG_LEN];

  // Golden architectural state
  logic [31:0] gold_regs [32];
  commit_t     exp_rec;
  int          commit_cnt;
  logic        rst_armed;

  // Memory model with one open request
  logic        resp_pend;
  logic [31:0] resp_addr;
  int          resp_wait;
  logic [31:0] next_addr;

  blimp_core blimp_core_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_req      (mem_req),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp     (mem_resp),
    .mem_resp_val (mem_resp_val),
    .trace        (trace),
    .trace_val    (trace_val)
  );

  always #5 clk = ~clk;

  // --------------------
  // Failure reporting
  // --------------------
  task automatic end_failed();
    $display("Test FAILED");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    end_failed();
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("FAIL %s expected 0x%h actual 0x%h", name, exp_val, act_val);
    end_failed();
  endtask

  // --------------------
  // Program and memory
  // --------------------
  // RV32I/M encodings straight from the ISA
  function automatic logic [31:0] encode_word(input int op, input logic [4:0] rd,
                                              input logic [4:0] rs1, input logic [4:0] rs2,
                                              input logic [11:0] imm);
    logic [31:0] w;
    case (op)
      K_ADD:   w = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
      K_MUL:   w = {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};
      default: w = {imm, rs1, 3'b000, rd, 7'b0010011};
    endcase
    return w;
  endfunction

  // Past the program end the core sees NOPs
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    logic [31:0] idx;
    idx = addr >> 2;
    if (addr[1:0] == 2'b00 && idx < PROG_LEN) begin
      return imem[idx];
    end
    return NOP_WORD;
  endfunction

  task automatic build_program();
    int back;
    for (int i = 0; i < PROG_LEN; i++) begin
      p_imm[i] = 12'($urandom);
      p_rs2[i] = 5'($urandom % 8);
      if (i < 8) begin
        // Load x1..x7 from x0 while slot 0 targets x0 itself
        p_op[i]  = K_ADDI;
        p_rd[i]  = 5'(i);
        p_rs1[i] = 5'd0;
      end else begin
        p_op[i]  = int'($urandom % 3);
        p_rd[i]  = 5'($urandom % 8);
        p_rs1[i] = 5'($urandom % 8);
        // About half read a recent destination
        if ($urandom % 2 == 0) begin
          back = 1 + int'($urandom % 3);
          if (p_op[i] == K_ADDI || $urandom % 2 == 0) begin
            p_rs1[i] = p_rd[i-back];
          end else begin
            p_rs2[i] = p_rd[i-back];
          end
        end
      end
      imem[i] = encode_word(p_op[i], p_rd[i], p_rs1[i], p_rs2[i], p_imm[i]);
    end
  endtask

  // --------------------
  // Golden model
  // --------------------
  function automatic commit_t predict_record(input int n);
    commit_t     r;
    logic [31:0] a;
    logic [31:0] b;
    logic [63:0] prod;
    r.pc = 32'(n * 4);
    if (n >= PROG_LEN) begin
      r.waddr = 5'd0;
      r.wen   = 1'b0;
      r.wdata = 32'd0;
      return r;
    end
    a       = gold_regs[p_rs1[n]];
    b       = gold_regs[p_rs2[n]];
    r.waddr = p_rd[n];
    r.wen   = (p_rd[n] != 5'd0);
    case (p_op[n])
      K_ADD:  r.wdata = a + b;
      K_ADDI: r.wdata = a + {{20{p_imm[n][11]}}, p_imm[n]};
      default: begin
        prod    = {32'd0, a} * {32'd0, b};
        r.wdata = prod[31:0];
      end
    endcase
    return r;
  endfunction

  // Retire the predicted record and predict the next one
  always @(posedge clk) begin
    if (rst_n && trace_val) begin
      if (exp_rec.wen) begin
        gold_regs[exp_rec.waddr] = exp_rec.wdata;
      end
      commit_cnt = commit_cnt + 1;
      exp_rec    = predict_record(commit_cnt);
    end
  end

  // Request taken at the edge and answered 0 to 4 cycles later
  always @(posedge clk) begin
    if (!rst_n) begin
      resp_pend = 1'b0;
      next_addr = '0;
    end else if (mem_req_val && mem_req_rdy) begin
      resp_pend = 1'b1;
      resp_addr = mem_req.addr;
      resp_wait = int'($urandom % 5);
      next_addr = next_addr + 32'd4;
    end
    #1;
    mem_resp_val = 1'b0;
    if (resp_pend) begin
      if (resp_wait == 0) begin
        mem_resp.data = fetch_word(resp_addr);
        mem_resp_val  = 1'b1;
        resp_pend     = 1'b0;
      end else begin
        resp_wait = resp_wait - 1;
      end
    end
    mem_req_rdy = ($urandom % 4 != 0) && rst_n;
  end

  // --------------------
  // Checks
  // --------------------
  reset_quiet_a: assert property (@(posedge clk)
    (rst_armed && !rst_n) |-> (!trace_val && !mem_req_val))
    else abort_run("trace_val or mem_req_val went high while rst_n was low");

  // Fetch walks the program one word at a time
  mem_addr_a: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req_val && mem_req_rdy) |-> (mem_req.addr == next_addr))
    else report_mismatch("mem_req.addr", $sampled(next_addr), $sampled(mem_req.addr));

  // Sequential pcs prove in-order commit with no loss or repeat
  trace_pc_a: assert property (@(posedge clk) disable iff (!rst_n)
    trace_val |-> (trace.pc == exp_rec.pc))
    else report_mismatch("trace.pc", $sampled(exp_rec.pc), $sampled(trace.pc));

  trace_waddr_a: assert property (@(posedge clk) disable iff (!rst_n)
    trace_val |-> (trace.waddr == exp_rec.waddr))
    else report_mismatch("trace.waddr", 32'($sampled(exp_rec.waddr)),
                         32'($sampled(trace.waddr)));

  // x0 destination commits without a write
  trace_wen_a: assert property (@(posedge clk) disable iff (!rst_n)
    trace_val |-> (trace.wen == exp_rec.wen))
    else report_mismatch("trace.wen", 32'($sampled(exp_rec.wen)),
                         32'($sampled(trace.wen)));

  trace_wdata_a: assert property (@(posedge clk) disable iff (!rst_n)
    (trace_val && exp_rec.wen) |-> (trace.wdata == exp_rec.wdata))
    else report_mismatch("trace.wdata", $sampled(exp_rec.wdata), $sampled(trace.wdata));

  // --------------------
  // Sequence
  // --------------------
  task automatic await_commits(input int target);
    int cycles;
    cycles = 0;
    while (commit_cnt < target) begin
      @(negedge clk);
      cycles++;
      if (cycles >= TIMEOUT) begin
        abort_run($sformatf("Core stalled with no commit for %0d cycles after %0d commits",
                            TIMEOUT, commit_cnt));
      end
    end
  endtask

  initial begin
    void'($urandom(37434));
    clk          = 1'b0;
    rst_n        = 1'b0;
    mem_req_rdy  = 1'b0;
    mem_resp     = '0;
    mem_resp_val = 1'b0;
    rst_armed    = 1'b0;
    commit_cnt   = 0;
    resp_pend    = 1'b0;
    resp_addr    = '0;
    resp_wait    = 0;
    next_addr    = '0;
    for (int r = 0; r < 32; r++) begin
      gold_regs[r] = 32'd0;
    end
    build_program();
    exp_rec = predict_record(0);

    // Reset for 10 cycles with the quiet check from the second edge
    @(posedge clk);
    #1;
    rst_armed = 1'b1;
    repeat (9) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (int n = 1; n <= PROG_LEN; n++) begin
      await_commits(n);
    end
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* include/blimp_defs.svh */
// --------------------
// Blimp core sizing macros
// Register count, sequence tag width, multiplier depth
// --------------------

`ifndef BLIMP_DEFS_SVH
`define BLIMP_DEFS_SVH

// Architectural integer registers
`define BLIMP_NUM_REGS 32

// Sequence tag width
// Reorder buffer holds 2**BLIMP_SEQ_BITS entries
`define BLIMP_SEQ_BITS 5

// Multiplier latency in cycles
`define BLIMP_MUL_STAGES 3

`endif

/* verilog.f */
+incdir+include
design/blimp_pkg.sv
design/fetch_unit.sv
design/decode_issue_unit.sv
design/alu_unit.sv
design/mul_unit.sv
design/writeback_commit_unit.sv
design/blimp_core.sv
dv/blimp_tb.sv
